// File: build.f
common/priv_pkg.sv
priv/priv_counters.sv
priv/priv_irq_pending.sv
priv/priv_csr_file.sv
priv/priv_trap_seq.sv
design/priv_block.sv
test/priv_assertions.sv
test/tb_priv_block.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_priv_block
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_priv_block.sv
`default_nettype none

module tb_priv_block;
    timeunit 1ns;
    timeprecision 100ps;

    import priv_pkg::*;

    typedef enum logic [3:0] {
        OP_SWAP, OP_SET, OP_CLEAR, OP_READ, OP_BAD, OP_WFI, OP_EXC, OP_MRET,
        OP_PRIV, OP_IRQ, OP_MASKED, OP_STALL, OP_CYCLE, OP_RETIRE
    } op_t;

    typedef struct packed {
        op_t       op;
        csr_addr_t addr;    // csr address, exception index or cycle count
        word_t     data;
        word_t     want;    // old rdata, readback, pc or flag
    } entry_t;

    localparam word_t ST_MIE   = word_t'(1) << MSTATUS_MIE_BIT;
    localparam word_t ST_MPIE  = word_t'(1) << MSTATUS_MPIE_BIT;
    localparam word_t ST_MPP_M = word_t'(3) << MSTATUS_MPP_LSB;
    localparam word_t IRQ_FLAG = 32'h8000_0000;

    logic        CLK;
    logic        rst_n;
    csr_addr_t   csr_addr;
    logic        csr_swap;
    logic        csr_set;
    logic        csr_clear;
    logic        csr_read_only;
    word_t       csr_wdata;
    logic        illegal_insn;
    logic        mal_insn;
    logic        fault_insn;
    logic        mal_l;
    logic        fault_l;
    logic        mal_s;
    logic        fault_s;
    logic        breakpoint;
    logic        env;
    word_t       epc;
    word_t       badaddr;
    logic        mret;
    logic        wfi;
    logic        instr_ret;
    logic        ex_mem_stall;
    logic        timer_int;
    logic        soft_int;
    logic        ext_int;
    word_t       csr_rdata;
    logic        invalid_priv_isn;
    logic        insert_pc;
    word_t       priv_pc;
    logic        intr;
    priv_level_t curr_priv;

    entry_t      tbl[$];
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;
    logic [15:0] lfsr = 16'd52136;

    priv_block i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    task automatic check_priv(input string name, input priv_level_t got,
                              input priv_level_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    task automatic add_entry(input op_t op, input csr_addr_t addr, input word_t data,
                             input word_t want);
        entry_t e;
        e.op = op;
        e.addr = addr;
        e.data = data;
        e.want = want;
        tbl.push_back(e);
    endtask

    // one cycle of csr access, sampled mid cycle
    task automatic csr_access(input csr_addr_t addr, input word_t data, input logic swap,
                              input logic set, input logic clear, input logic ro,
                              output word_t rdata, output logic bad);
        csr_addr = addr;
        csr_wdata = data;
        csr_swap = swap;
        csr_set = set;
        csr_clear = clear;
        csr_read_only = ro;
        @(negedge CLK);
        rdata = csr_rdata;
        bad = invalid_priv_isn;
        next_cycle();
        csr_swap = 1'b0;
        csr_set = 1'b0;
        csr_clear = 1'b0;
        csr_read_only = 1'b0;
    endtask

    task automatic set_exc(input csr_addr_t which, input logic v);
        case (which)
            12'd0:   illegal_insn = v;
            12'd1:   env = v;
            12'd2:   mal_l = v;
            default: breakpoint = v;
        endcase
    endtask

    task automatic set_lines(input logic [2:0] lines);
        timer_int = lines[0];
        soft_int = lines[1];
        ext_int = lines[2];
    endtask

    // n counts the cycles before the one with insert_pc
    task automatic wait_redirect(input int limit, output int n, output word_t pc,
                                 output logic irq);
        logic seen;
        seen = 1'b0;
        n = 0;
        pc = '0;
        irq = 1'b0;
        while (!seen && n < limit) begin
            @(negedge CLK);
            if (insert_pc) begin
                seen = 1'b1;
                pc = priv_pc;
                irq = intr;
            end else begin
                n++;
            end
            next_cycle();
        end
        if (!seen) begin
            errors++;
            $display("no pc redirect seen within %0d cycles", limit);
        end
    endtask

    task automatic build_table();
        word_t scratch;
        word_t tvec;
        word_t d;
        word_t pc1;
        word_t pc2;
        word_t pc3;
        d = rand_bits(32);
        add_entry(OP_SWAP, CSR_MSCRATCH, d, 32'h0);
        scratch = d;
        add_entry(OP_READ, CSR_MSCRATCH, rand_bits(32), scratch);
        d = rand_bits(32);
        add_entry(OP_SET, CSR_MSCRATCH, d, scratch);
        scratch = scratch | d;
        add_entry(OP_READ, CSR_MSCRATCH, rand_bits(32), scratch);
        d = rand_bits(32);
        add_entry(OP_CLEAR, CSR_MSCRATCH, d, scratch);
        scratch = scratch & ~d;
        add_entry(OP_READ, CSR_MSCRATCH, rand_bits(32), scratch);
        d = rand_bits(32) & 32'hffff_fffc;
        add_entry(OP_SWAP, CSR_MTVEC, d, 32'h0);
        tvec = d;
        d = rand_bits(32) & 32'h0000_00f0;
        add_entry(OP_SET, CSR_MTVEC, d, tvec);
        tvec = tvec | d;
        add_entry(OP_READ, CSR_MTVEC, rand_bits(32), tvec);
        add_entry(OP_BAD, CSR_MHARTID, rand_bits(32), 32'h1);
        add_entry(OP_READ, CSR_MHARTID, rand_bits(32), HART_ID);
        add_entry(OP_BAD, 12'h7c0, rand_bits(32), 32'h1);     // unknown address
        // illegal instruction with mie set beforehand
        add_entry(OP_SWAP, CSR_MSTATUS, ST_MIE, 32'h0);
        pc1 = rand_bits(32) & 32'hffff_fffc;
        add_entry(OP_EXC, 12'd0, pc1, tvec);
        add_entry(OP_READ, CSR_MEPC, rand_bits(32), pc1);
        add_entry(OP_READ, CSR_MCAUSE, rand_bits(32), word_t'(EXC_ILLEGAL));
        add_entry(OP_READ, CSR_MTVAL, rand_bits(32), 32'h0);
        add_entry(OP_READ, CSR_MSTATUS, rand_bits(32), ST_MPIE | ST_MPP_M);
        add_entry(OP_PRIV, 12'd0, 32'h0, word_t'(PRIV_M));
        // drop to user mode through mret
        add_entry(OP_CLEAR, CSR_MSTATUS, ST_MPP_M, ST_MPIE | ST_MPP_M);
        add_entry(OP_MRET, 12'd0, 32'h0, pc1);
        add_entry(OP_PRIV, 12'd0, 32'h0, word_t'(PRIV_U));
        add_entry(OP_BAD, CSR_MSCRATCH, rand_bits(32), 32'h1);
        add_entry(OP_WFI, 12'd0, 32'h0, 32'h1);
        pc2 = rand_bits(32) & 32'hffff_fffc;
        add_entry(OP_EXC, 12'd1, pc2, tvec);
        add_entry(OP_PRIV, 12'd0, 32'h0, word_t'(PRIV_M));
        add_entry(OP_READ, CSR_MCAUSE, rand_bits(32), word_t'(EXC_ECALL_U));
        add_entry(OP_READ, CSR_MEPC, rand_bits(32), pc2);
        add_entry(OP_READ, CSR_MSCRATCH, rand_bits(32), scratch);
        add_entry(OP_WFI, 12'd0, 32'h0, 32'h0);
        pc3 = rand_bits(32) & 32'hffff_fffc;
        add_entry(OP_EXC, 12'd2, pc3, tvec);                  // misaligned load
        add_entry(OP_READ, CSR_MCAUSE, rand_bits(32), word_t'(EXC_LOAD_MISAL));
        add_entry(OP_READ, CSR_MTVAL, rand_bits(32), pc3 + 32'h101);
        // interrupts, mstatus is mpp=m with both enables clear here
        add_entry(OP_SWAP, CSR_MIE, 32'h0000_0888, 32'h0);
        add_entry(OP_SET, CSR_MSTATUS, ST_MIE, ST_MPP_M);
        add_entry(OP_IRQ, 12'd0, 32'h1, tvec);
        add_entry(OP_READ, CSR_MCAUSE, rand_bits(32), IRQ_FLAG | word_t'(IRQ_MTI));
        add_entry(OP_SET, CSR_MSTATUS, ST_MIE, ST_MPIE | ST_MPP_M);
        add_entry(OP_IRQ, 12'd0, 32'h5, tvec);                // timer and external
        add_entry(OP_READ, CSR_MCAUSE, rand_bits(32), IRQ_FLAG | word_t'(IRQ_MEI));
        add_entry(OP_MASKED, 12'd6, 32'h1, 32'h0);
        add_entry(OP_SET, CSR_MSTATUS, ST_MIE, ST_MPIE | ST_MPP_M);
        add_entry(OP_STALL, 12'd4, 32'h2, tvec);
        add_entry(OP_READ, CSR_MCAUSE, rand_bits(32), IRQ_FLAG | word_t'(IRQ_MSI));
        d = rand_bits(32);
        add_entry(OP_CYCLE, 12'd5, d, d + 32'd5);
        d = rand_bits(32);
        add_entry(OP_CYCLE, 12'd12, d, d + 32'd12);
        d = rand_bits(32);                                     // retire low, stall high
        add_entry(OP_RETIRE, 12'd16, d, word_t'($countones(d[15:0] & ~d[31:16])));
    endtask

    task automatic run_entry(input entry_t e);
        word_t rd;
        logic  bad;
        word_t pc;
        logic  irq;
        int    n;
        int    k;
        case (e.op)
            OP_SWAP, OP_SET, OP_CLEAR: begin
                csr_access(e.addr, e.data, e.op == OP_SWAP, e.op == OP_SET,
                           e.op == OP_CLEAR, 1'b0, rd, bad);
                check_word("csr_rdata", rd, e.want);
                check_bit("invalid_priv_isn", bad, 1'b0);
            end
            OP_READ: begin
                csr_access(e.addr, e.data, 1'b0, 1'b1, 1'b0, 1'b1, rd, bad);
                check_word("csr_rdata", rd, e.want);
                check_bit("invalid_priv_isn", bad, 1'b0);
            end
            OP_BAD: begin
                csr_access(e.addr, e.data, 1'b1, 1'b0, 1'b0, 1'b0, rd, bad);
                check_bit("invalid_priv_isn", bad, e.want[0]);
            end
            OP_WFI: begin
                wfi = 1'b1;
                @(negedge CLK);
                check_bit("invalid_priv_isn", invalid_priv_isn, e.want[0]);
                next_cycle();
                wfi = 1'b0;
            end
            OP_EXC: begin
                set_exc(e.addr, 1'b1);
                epc = e.data;
                badaddr = e.data + 32'h101;
                next_cycle();
                set_exc(e.addr, 1'b0);
                wait_redirect(8, n, pc, irq);
                check_word("insert_pc delay", word_t'(n), 32'd1);
                check_word("priv_pc", pc, e.want);
                check_bit("intr", irq, 1'b0);
            end
            OP_MRET: begin
                mret = 1'b1;
                next_cycle();
                mret = 1'b0;
                wait_redirect(8, n, pc, irq);
                check_word("insert_pc delay", word_t'(n), 32'd0);
                check_word("priv_pc", pc, e.want);
                check_bit("intr", irq, 1'b0);
            end
            OP_PRIV: begin
                @(negedge CLK);
                check_priv("curr_priv", curr_priv, e.want[1:0]);
                next_cycle();
            end
            OP_IRQ, OP_STALL: begin
                set_lines(e.data[2:0]);
                ex_mem_stall = (e.op == OP_STALL);
                for (k = 0; k < int'(e.addr); k++) begin
                    @(negedge CLK);
                    check_bit("insert_pc", insert_pc, 1'b0);
                    next_cycle();
                end
                ex_mem_stall = 1'b0;
                wait_redirect(8, n, pc, irq);
                check_word("priv_pc", pc, e.want);
                check_bit("intr", irq, 1'b1);
                set_lines(3'b000);
                repeat (2) next_cycle();    // let mip drain
            end
            OP_MASKED: begin
                set_lines(e.data[2:0]);
                repeat (e.addr) begin
                    @(negedge CLK);
                    check_bit("insert_pc", insert_pc, 1'b0);
                    next_cycle();
                end
                set_lines(3'b000);
                repeat (2) next_cycle();
            end
            OP_CYCLE: begin
                csr_access(CSR_MCYCLE, e.data, 1'b1, 1'b0, 1'b0, 1'b0, rd, bad);
                repeat (e.addr) next_cycle();
                csr_access(CSR_MCYCLE, e.data, 1'b0, 1'b1, 1'b0, 1'b1, rd, bad);
                check_word("csr_rdata", rd, e.want);
            end
            OP_RETIRE: begin
                csr_access(CSR_MINSTRET, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, rd, bad);
                for (k = 0; k < int'(e.addr); k++) begin
                    instr_ret = e.data[k];
                    ex_mem_stall = e.data[16 + k];
                    next_cycle();
                end
                instr_ret = 1'b0;
                ex_mem_stall = 1'b0;
                csr_access(CSR_MINSTRET, 32'h0, 1'b0, 1'b1, 1'b0, 1'b1, rd, bad);
                check_word("csr_rdata", rd, e.want);
            end
            default: ;
        endcase
    endtask

    initial begin
        int  err_before;
        op_t op;
        rst_n = 1'b0;
        csr_addr = '0;
        csr_swap = 1'b0;
        csr_set = 1'b0;
        csr_clear = 1'b0;
        csr_read_only = 1'b0;
        csr_wdata = '0;
        illegal_insn = 1'b0;
        mal_insn = 1'b0;
        fault_insn = 1'b0;
        mal_l = 1'b0;
        fault_l = 1'b0;
        mal_s = 1'b0;
        fault_s = 1'b0;
        breakpoint = 1'b0;
        env = 1'b0;
        epc = '0;
        badaddr = '0;
        mret = 1'b0;
        wfi = 1'b0;
        instr_ret = 1'b0;
        ex_mem_stall = 1'b0;
        set_lines(3'b000);
        build_table();
        cycle_limit = tbl.size() * 8 + 50;
        repeat (2) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        foreach (tbl[i]) begin
            err_before = errors;
            op = tbl[i].op;
            run_entry(tbl[i]);
            $display("test %0d %s %s", i, op.name(), (errors == err_before) ? "ok" : "mismatch");
        end
        $display("%0d tests, %0d checks, %0d errors", tbl.size(), checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/priv_assertions.sv
`default_nettype none

module priv_assertions (
    input logic                  CLK,
    input logic                  rst_n,
    input logic                  trap_save,
    input logic                  insert_pc,
    input priv_pkg::word_t       trap_epc,
    input priv_pkg::word_t       mepc,
    input priv_pkg::priv_level_t curr_priv
);
    timeunit 1ns;
    timeprecision 100ps;

    import priv_pkg::*;

    redirect_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
        insert_pc |=> !insert_pc)
        else $error("insert_pc held longer than one cycle");

    // the csr file has stored the trap by the time the redirect goes out
    save_then_redirect: assert property (@(posedge CLK) disable iff (!rst_n)
        trap_save |=> insert_pc && (mepc == $past(trap_epc)) && (curr_priv == PRIV_M))
        else $error("trap_save not followed by insert_pc with mepc and level updated");

    quiet_in_reset: assert property (@(posedge CLK) !rst_n |=> !insert_pc)
        else $error("insert_pc raised while in reset");

endmodule

bind priv_trap_seq priv_assertions i_assertions (.*);

`default_nettype wire

// File: design/priv_block.sv
`default_nettype none

module priv_block (
    input  logic                  CLK,
    input  logic                  rst_n,
    // csr access from execute
    input  priv_pkg::csr_addr_t   csr_addr,
    input  logic                  csr_swap,
    input  logic                  csr_set,
    input  logic                  csr_clear,
    input  logic                  csr_read_only,
    input  priv_pkg::word_t       csr_wdata,
    // exception flags
    input  logic                  illegal_insn,
    input  logic                  mal_insn,
    input  logic                  fault_insn,
    input  logic                  mal_l,
    input  logic                  fault_l,
    input  logic                  mal_s,
    input  logic                  fault_s,
    input  logic                  breakpoint,
    input  logic                  env,
    input  priv_pkg::word_t       epc,
    input  priv_pkg::word_t       badaddr,
    input  logic                  mret,
    input  logic                  wfi,
    input  logic                  instr_ret,
    input  logic                  ex_mem_stall,
    input  logic                  timer_int,
    input  logic                  soft_int,
    input  logic                  ext_int,
    output priv_pkg::word_t       csr_rdata,
    output logic                  invalid_priv_isn,
    output logic                  insert_pc,
    output priv_pkg::word_t       priv_pc,
    output logic                  intr,
    output priv_pkg::priv_level_t curr_priv
);
    import priv_pkg::*;

    // sequencer and csr file
    logic      trap_save;
    exc_code_t trap_cause;
    logic      trap_is_irq;
    word_t     trap_epc;
    word_t     trap_tval;
    logic      do_mret;
    word_t     mtvec;
    word_t     mepc;
    logic      mstatus_mie;

    // interrupt side
    word_t     mie_reg;
    logic      global_ie;
    word_t     mip;
    logic      irq_valid;
    exc_code_t irq_code;

    // counter write-back and readout
    logic      cnt_we;
    logic      cnt_sel;
    word_t     mcycle;
    word_t     minstret;

    priv_csr_file i_csr_file (.*);

    priv_trap_seq i_trap_seq (.*);

    priv_counters i_counters (.*);

    priv_irq_pending i_irq_pending (.*);

endmodule

`default_nettype wire

// File: priv/priv_trap_seq.sv
`default_nettype none

module priv_trap_seq (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  illegal_insn,
    input  logic                  mal_insn,
    input  logic                  fault_insn,
    input  logic                  mal_l,
    input  logic                  fault_l,
    input  logic                  mal_s,
    input  logic                  fault_s,
    input  logic                  breakpoint,
    input  logic                  env,
    input  priv_pkg::word_t       epc,
    input  priv_pkg::word_t       badaddr,
    input  logic                  mret,
    input  priv_pkg::priv_level_t curr_priv,
    input  logic                  irq_valid,
    input  priv_pkg::exc_code_t   irq_code,
    input  logic                  ex_mem_stall,
    input  logic                  mstatus_mie,
    input  priv_pkg::word_t       mtvec,
    input  priv_pkg::word_t       mepc,
    output logic                  trap_save,
    output priv_pkg::exc_code_t   trap_cause,
    output logic                  trap_is_irq,
    output priv_pkg::word_t       trap_epc,
    output priv_pkg::word_t       trap_tval,
    output logic                  do_mret,
    output logic                  insert_pc,
    output priv_pkg::word_t       priv_pc,
    output logic                  intr
);
    import priv_pkg::*;

    trap_state_t state;
    exc_code_t   exc_code;
    logic        addr_fault;
    logic        exc_any;
    logic        irq_take;
    logic        trap_req;
    logic        mret_q;

    // fixed exception priority, instruction side first
    always_comb begin
        exc_code = EXC_ILLEGAL;
        addr_fault = 1'b0;
        if (fault_insn) begin
            exc_code = EXC_INSN_FAULT;
            addr_fault = 1'b1;
        end else if (mal_insn) begin
            exc_code = EXC_INSN_MISAL;
            addr_fault = 1'b1;
        end else if (illegal_insn) begin
            exc_code = EXC_ILLEGAL;
        end else if (breakpoint) begin
            exc_code = EXC_BREAK;
        end else if (env) begin
            exc_code = (curr_priv == PRIV_U) ? EXC_ECALL_U : EXC_ECALL_M;
        end else if (mal_l) begin
            exc_code = EXC_LOAD_MISAL;
            addr_fault = 1'b1;
        end else if (fault_l) begin
            exc_code = EXC_LOAD_FAULT;
            addr_fault = 1'b1;
        end else if (mal_s) begin
            exc_code = EXC_STORE_MISAL;
            addr_fault = 1'b1;
        end else if (fault_s) begin
            exc_code = EXC_STORE_FAULT;
            addr_fault = 1'b1;
        end
    end

    assign exc_any = fault_insn | mal_insn | illegal_insn | breakpoint | env
                     | mal_l | fault_l | mal_s | fault_s;
    // a stalled ex/mem stage holds off interrupts only
    assign irq_take = irq_valid & ~ex_mem_stall & (mstatus_mie | (curr_priv == PRIV_U));
    assign trap_req = (state == TRAP_IDLE) & (exc_any | irq_take);
    assign do_mret = mret & (curr_priv == PRIV_M) & (state == TRAP_IDLE) & ~trap_req;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state <= TRAP_IDLE;
            mret_q <= 1'b0;
        end else begin
            mret_q <= do_mret;
            case (state)
                TRAP_IDLE:     state <= trap_req ? TRAP_SAVE : TRAP_IDLE;
                TRAP_SAVE:     state <= TRAP_REDIRECT;
                TRAP_REDIRECT: state <= TRAP_IDLE;
                default:       state <= TRAP_IDLE;
            endcase
        end
    end

    // cause and addresses captured with the request
    always_ff @(posedge CLK) begin
        if (trap_req) begin
            trap_cause <= exc_any ? exc_code : irq_code;
            trap_is_irq <= ~exc_any;
            trap_epc <= epc;
            trap_tval <= (exc_any & addr_fault) ? badaddr : '0;
        end
    end

    assign trap_save = (state == TRAP_SAVE);
    assign insert_pc = (state == TRAP_REDIRECT) | mret_q;
    assign priv_pc = (state == TRAP_REDIRECT) ? mtvec : mepc;
    assign intr = (state == TRAP_REDIRECT) & trap_is_irq;

endmodule

`default_nettype wire

// File: priv/priv_csr_file.sv
`default_nettype none

module priv_csr_file (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  priv_pkg::csr_addr_t   csr_addr,
    input  logic                  csr_swap,
    input  logic                  csr_set,
    input  logic                  csr_clear,
    input  logic                  csr_read_only,
    input  priv_pkg::word_t       csr_wdata,
    input  logic                  mret,
    input  logic                  wfi,
    input  logic                  trap_save,
    input  priv_pkg::exc_code_t   trap_cause,
    input  logic                  trap_is_irq,
    input  priv_pkg::word_t       trap_epc,
    input  priv_pkg::word_t       trap_tval,
    input  logic                  do_mret,
    input  priv_pkg::word_t       mip,
    input  priv_pkg::word_t       mcycle,
    input  priv_pkg::word_t       minstret,
    output priv_pkg::word_t       csr_rdata,
    output logic                  invalid_priv_isn,
    output priv_pkg::word_t       mtvec,
    output priv_pkg::word_t       mepc,
    output logic                  mstatus_mie,
    output priv_pkg::word_t       mie_reg,
    output logic                  global_ie,
    output priv_pkg::priv_level_t curr_priv,
    output logic                  cnt_we,
    output logic                  cnt_sel
);
    import priv_pkg::*;

    logic        status_mpie;
    priv_level_t status_mpp;
    word_t       mcause_q;
    word_t       mtval_q;
    word_t       mscratch_q;
    word_t       status_word;
    word_t       irq_mask;
    word_t       wval;
    logic        addr_known;
    logic        csr_op;
    logic        csr_write;
    logic        csr_bad;
    logic        csr_we;

    // only mie, mpie and mpp exist in mstatus
    always_comb begin
        status_word = '0;
        status_word[MSTATUS_MIE_BIT] = mstatus_mie;
        status_word[MSTATUS_MPIE_BIT] = status_mpie;
        status_word[MSTATUS_MPP_LSB +: 2] = status_mpp;
        irq_mask = '0;
        irq_mask[IRQ_MSI] = 1'b1;
        irq_mask[IRQ_MTI] = 1'b1;
        irq_mask[IRQ_MEI] = 1'b1;
    end

    always_comb begin
        addr_known = 1'b1;
        csr_rdata = '0;
        case (csr_addr)
            CSR_MSTATUS:  csr_rdata = status_word;
            CSR_MIE:      csr_rdata = mie_reg;
            CSR_MTVEC:    csr_rdata = mtvec;
            CSR_MSCRATCH: csr_rdata = mscratch_q;
            CSR_MEPC:     csr_rdata = mepc;
            CSR_MCAUSE:   csr_rdata = mcause_q;
            CSR_MTVAL:    csr_rdata = mtval_q;
            CSR_MIP:      csr_rdata = mip;      // writes are ignored
            CSR_MCYCLE:   csr_rdata = mcycle;
            CSR_MINSTRET: csr_rdata = minstret;
            CSR_MHARTID:  csr_rdata = HART_ID;
            default:      addr_known = 1'b0;
        endcase
    end

    assign csr_op = $onehot({csr_swap, csr_set, csr_clear});
    assign csr_write = csr_op & ~csr_read_only;

    // every csr here is machine level, so any access from u mode faults
    assign csr_bad = csr_op & (~addr_known | (curr_priv == PRIV_U)
                     | (csr_write & (csr_addr == CSR_MHARTID)));
    assign invalid_priv_isn = csr_bad | ((mret | wfi) & (curr_priv == PRIV_U));
    assign csr_we = csr_write & ~csr_bad;

    always_comb begin
        if (csr_set)
            wval = csr_rdata | csr_wdata;
        else if (csr_clear)
            wval = csr_rdata & ~csr_wdata;
        else
            wval = csr_wdata;
    end

    // counters take whole-word writes only
    assign cnt_we = csr_we & csr_swap
                    & ((csr_addr == CSR_MCYCLE) | (csr_addr == CSR_MINSTRET));
    assign cnt_sel = (csr_addr == CSR_MINSTRET);

    assign global_ie = mstatus_mie | (curr_priv == PRIV_U);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mstatus_mie <= 1'b0;
            status_mpie <= 1'b0;
            status_mpp <= PRIV_U;
            mie_reg <= '0;
            mtvec <= '0;
            mscratch_q <= '0;
            mepc <= '0;
            mcause_q <= '0;
            mtval_q <= '0;
            curr_priv <= PRIV_M;
        end else if (trap_save) begin
            mepc <= trap_epc;
            mcause_q <= {trap_is_irq, 26'd0, trap_cause};
            mtval_q <= trap_tval;
            status_mpie <= mstatus_mie;
            mstatus_mie <= 1'b0;
            status_mpp <= curr_priv;
            curr_priv <= PRIV_M;
        end else if (do_mret) begin
            mstatus_mie <= status_mpie;
            status_mpie <= 1'b1;
            curr_priv <= status_mpp;
            status_mpp <= PRIV_U;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MSTATUS: begin
                    mstatus_mie <= wval[MSTATUS_MIE_BIT];
                    status_mpie <= wval[MSTATUS_MPIE_BIT];
                    // mpp holds only the levels that exist
                    status_mpp <= (wval[MSTATUS_MPP_LSB +: 2] == PRIV_M) ? PRIV_M : PRIV_U;
                end
                CSR_MIE:      mie_reg <= wval & irq_mask;
                CSR_MTVEC:    mtvec <= wval;    // direct mode
                CSR_MSCRATCH: mscratch_q <= wval;
                CSR_MEPC:     mepc <= wval;
                CSR_MCAUSE:   mcause_q <= wval;
                CSR_MTVAL:    mtval_q <= wval;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: priv/priv_irq_pending.sv
`default_nettype none

module priv_irq_pending (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                timer_int,
    input  logic                soft_int,
    input  logic                ext_int,
    input  priv_pkg::word_t     mie_reg,
    input  logic                global_ie,
    output priv_pkg::word_t     mip,
    output logic                irq_valid,
    output priv_pkg::exc_code_t irq_code
);
    import priv_pkg::*;

    logic  msip;
    logic  mtip;
    logic  meip;
    word_t pend;

    // level lines, sampled once per cycle
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            msip <= 1'b0;
            mtip <= 1'b0;
            meip <= 1'b0;
        end else begin
            msip <= soft_int;
            mtip <= timer_int;
            meip <= ext_int;
        end
    end

    always_comb begin
        mip = '0;
        mip[IRQ_MSI] = msip;
        mip[IRQ_MTI] = mtip;
        mip[IRQ_MEI] = meip;
    end

    assign pend = mip & mie_reg;
    assign irq_valid = global_ie & (|pend);

    // external over software over timer
    always_comb begin
        if (pend[IRQ_MEI])
            irq_code = IRQ_MEI;
        else if (pend[IRQ_MSI])
            irq_code = IRQ_MSI;
        else
            irq_code = IRQ_MTI;
    end

endmodule

`default_nettype wire

// File: priv/priv_counters.sv
`default_nettype none

module priv_counters (
    input  logic            CLK,
    input  logic            rst_n,
    input  logic            instr_ret,
    input  logic            ex_mem_stall,
    input  logic            cnt_we,
    input  logic            cnt_sel,    // 0 mcycle, 1 minstret
    input  priv_pkg::word_t csr_wdata,
    output priv_pkg::word_t mcycle,
    output priv_pkg::word_t minstret
);

    logic retire;

    // a retire during a stall is counted when the stage moves on
    assign retire = instr_ret & ~ex_mem_stall;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mcycle <= '0;
            minstret <= '0;
        end else begin
            if (cnt_we && !cnt_sel)
                mcycle <= csr_wdata;    // write wins over the increment
            else
                mcycle <= mcycle + 32'd1;

            if (cnt_we && cnt_sel)
                minstret <= csr_wdata;
            else if (retire)
                minstret <= minstret + 32'd1;
        end
    end

endmodule

`default_nettype wire

// File: common/priv_pkg.sv
`default_nettype none

package priv_pkg;

    typedef logic [31:0] word_t;       // csr data, pcs and tval
    typedef logic [11:0] csr_addr_t;
    typedef logic [1:0]  priv_level_t;
    typedef logic [4:0]  exc_code_t;   // cause without the interrupt bit

    typedef enum logic [1:0] {
        TRAP_IDLE,
        TRAP_SAVE,
        TRAP_REDIRECT
    } trap_state_t;

    // privilege levels, supervisor is not implemented
    localparam priv_level_t PRIV_U = 2'd0;
    localparam priv_level_t PRIV_M = 2'd3;

    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MCYCLE   = 12'hb00;
    localparam csr_addr_t CSR_MINSTRET = 12'hb02;
    localparam csr_addr_t CSR_MHARTID  = 12'hf14;

    // synchronous exception codes
    localparam exc_code_t EXC_INSN_MISAL  = 5'd0;
    localparam exc_code_t EXC_INSN_FAULT  = 5'd1;
    localparam exc_code_t EXC_ILLEGAL     = 5'd2;
    localparam exc_code_t EXC_BREAK       = 5'd3;
    localparam exc_code_t EXC_LOAD_MISAL  = 5'd4;
    localparam exc_code_t EXC_LOAD_FAULT  = 5'd5;
    localparam exc_code_t EXC_STORE_MISAL = 5'd6;
    localparam exc_code_t EXC_STORE_FAULT = 5'd7;
    localparam exc_code_t EXC_ECALL_U     = 5'd8;
    localparam exc_code_t EXC_ECALL_M     = 5'd11;

    // interrupt codes, also the bit positions in mip and mie
    localparam exc_code_t IRQ_MSI = 5'd3;
    localparam exc_code_t IRQ_MTI = 5'd7;
    localparam exc_code_t IRQ_MEI = 5'd11;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;   // mpp spans two bits

    localparam word_t HART_ID = 32'd0;

endpackage

`default_nettype wire
